// ==== list.f ====
+incdir+rtl
rtl/axi_wr_pkg.sv
rtl/writer_ctl_pkg.sv
rtl/packet_fifo.sv
rtl/packet_length_queue.sv
rtl/burst_planner.sv
rtl/write_sequencer.sv
rtl/axi_packet_writer.sv
tests/axi_packet_writer_sva.sv
tests/axi_packet_writer_tb.sv

// ==== Makefile ====
TOP := axi_packet_writer_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); status=$$?; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

// ==== tests/axi_packet_writer_tb.sv ====
`timescale 1ns/10ps
`include "mem_writer_cfg.svh"

module axi_packet_writer_tb;
    import axi_wr_pkg::*;
    import writer_ctl_pkg::*;

    localparam int MAX_LEN    = 40;
    localparam int NUM_PKTS   = 66;
    localparam int WAIT_LIMIT = 20000;

    logic        CLK;
    logic        RESET;
    logic        RUN;
    logic        STOP;
    addr_t       MEM_BASEADDR;
    logic        MEM_BASEADDR_VALID;
    addr_t       MEM_HIGHADDR;
    data_t       S_AXIS_TDATA;
    logic        S_AXIS_TVALID;
    logic        S_AXIS_TLAST;
    logic        S_AXIS_TREADY;
    addr_t       M_AXI_AWADDR;
    awlen_t      M_AXI_AWLEN;
    logic        M_AXI_AWVALID;
    logic        M_AXI_AWREADY;
    data_t       M_AXI_WDATA;
    logic        M_AXI_WLAST;
    logic        M_AXI_WVALID;
    logic        M_AXI_WREADY;
    logic        M_AXI_BVALID;
    logic        M_AXI_BREADY;
    logic        STATUS;
    byte_count_t TRANSMITTED_BYTES;
    logic        TRANSMITTED_FLAG;
    addr_t       CURRENT_ADDRESS;

    // stimulus pool, drawn once at time zero
    int    pkt_len  [NUM_PKTS];
    data_t data_pool[NUM_PKTS * MAX_LEN];
    int    gap_pool [NUM_PKTS * MAX_LEN];

    // reference model
    data_t exp_data[$];
    int    exp_len[$];
    addr_t done_addr_q[$];
    int    done_len_q[$];
    addr_t model_addr;
    addr_t pkt_start;
    int    pkt_words;
    int    pkt_remaining;
    int    burst_beats;
    int    beat_idx;
    bit    expect_base;
    int    wraps;
    int    b_pending;
    int    words_sent;
    int    beats_seen;
    int    checks;
    int    errors;

    axi_packet_writer i_axi_packet_writer (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_address(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_awlen(input string name, input awlen_t got, input awlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_bytes(input string name, input byte_count_t got,
                                 input byte_count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t: no progress while waiting for %s", $time, what);
        $display("Simulation failed");
        $finish;
    endtask

    // model of one accepted AW burst: smallest of limit, boundary and packet rest
    task automatic model_burst();
        int bound;
        int n;
        if (pkt_remaining == 0) begin
            if (exp_len.size() == 0) begin
                report_error("address burst issued with no packet pending");
                return;
            end
            pkt_remaining = exp_len.pop_front();
            pkt_words     = pkt_remaining;
            pkt_start     = model_addr;
        end
        if (expect_base) begin
            check_address("M_AXI_AWADDR at base", M_AXI_AWADDR, MEM_BASEADDR);
            if (M_AXI_AWADDR === MEM_BASEADDR) wraps++;
            expect_base = 1'b0;
        end
        check_address("M_AXI_AWADDR", M_AXI_AWADDR, model_addr);
        bound = (`WR_BOUND_BYTES - int'(model_addr[11:0])) / `WR_BYTES_PER_WORD;
        n = `WR_BURST_LIMIT;
        if (bound < n) n = bound;
        if (pkt_remaining < n) n = pkt_remaining;
        compare_awlen("M_AXI_AWLEN", M_AXI_AWLEN, awlen_t'(n - 1));
        burst_beats   = n;
        beat_idx      = 0;
        model_addr    = model_addr + addr_t'(n * `WR_BYTES_PER_WORD);
        pkt_remaining = pkt_remaining - n;
        if (pkt_remaining == 0) begin
            done_addr_q.push_back(pkt_start);
            done_len_q.push_back(pkt_words);
            if (model_addr >= MEM_HIGHADDR) begin
                model_addr  = MEM_BASEADDR;
                expect_base = 1'b1;
            end
        end
    endtask

    task automatic model_beat();
        if (exp_data.size() == 0) begin
            report_error("write beat with no data expected");
        end else begin
            check_data("M_AXI_WDATA", M_AXI_WDATA, exp_data.pop_front());
        end
        checks++;
        if (M_AXI_WLAST !== (beat_idx == burst_beats - 1)) begin
            errors++;
            $display("mismatch at %0t: M_AXI_WLAST got %b expected %b", $time,
                     M_AXI_WLAST, beat_idx == burst_beats - 1);
        end
        beat_idx++;
        beats_seen++;
    endtask

    task automatic model_completion();
        int len;
        if (done_len_q.size() == 0) begin
            report_error("completion pulse with no packet finished");
        end else begin
            len = done_len_q.pop_front();
            compare_bytes("TRANSMITTED_BYTES", TRANSMITTED_BYTES,
                          byte_count_t'(len * `WR_BYTES_PER_WORD));
            check_address("CURRENT_ADDRESS", CURRENT_ADDRESS, done_addr_q.pop_front());
        end
    endtask

    // memory side: sample at the falling edge, drive ready and response after the rise
    initial begin : memory_model
        bit aw_fire;
        bit w_fire;
        bit b_fire;
        forever begin
            @(negedge CLK);
            aw_fire = M_AXI_AWVALID && M_AXI_AWREADY;
            w_fire  = M_AXI_WVALID && M_AXI_WREADY;
            b_fire  = M_AXI_BVALID && M_AXI_BREADY;
            if (!RESET) begin
                if (aw_fire) model_burst();
                if (w_fire) model_beat();
                if (TRANSMITTED_FLAG) model_completion();
                if (w_fire && M_AXI_WLAST) b_pending++;
                if (b_fire) b_pending--;
            end
            @(posedge CLK);
            #2;
            M_AXI_AWREADY = ($urandom % 4) != 0;
            M_AXI_WREADY  = ($urandom % 4) != 0;
            if (b_fire) begin
                M_AXI_BVALID = 1'b0;
            end else if (!M_AXI_BVALID && b_pending > 0 && ($urandom % 3) == 0) begin
                M_AXI_BVALID = 1'b1;
            end
        end
    end

    task automatic send_packet(input int p);
        int len;
        int waited;
        bit fired;
        len = pkt_len[p];
        for (int w = 0; w < len; w++) begin
            exp_data.push_back(data_pool[p * MAX_LEN + w]);
        end
        exp_len.push_back(len);
        words_sent += len;
        for (int w = 0; w < len; w++) begin
            if (gap_pool[p * MAX_LEN + w] > 0) begin
                S_AXIS_TVALID = 1'b0;
                repeat (gap_pool[p * MAX_LEN + w]) begin
                    @(posedge CLK);
                    #2;
                end
            end
            S_AXIS_TVALID = 1'b1;
            S_AXIS_TDATA  = data_pool[p * MAX_LEN + w];
            S_AXIS_TLAST  = (w == len - 1);
            waited = 0;
            fired  = 1'b0;
            while (!fired) begin
                @(negedge CLK);
                fired = S_AXIS_TREADY;
                @(posedge CLK);
                #2;
                waited++;
                if (waited > WAIT_LIMIT) abort_on_timeout("S_AXIS_TREADY");
            end
        end
        S_AXIS_TVALID = 1'b0;
        S_AXIS_TLAST  = 1'b0;
    endtask

    task automatic pulse_run();
        RUN = 1'b1;
        @(posedge CLK);
        #2;
        RUN = 1'b0;
    endtask

    task automatic wait_model_drained();
        int waited;
        waited = 0;
        while (exp_len.size() != 0 || exp_data.size() != 0 || pkt_remaining != 0 ||
               done_len_q.size() != 0) begin
            @(negedge CLK);
            waited++;
            if (waited > WAIT_LIMIT) abort_on_timeout("all packets written");
        end
        @(posedge CLK);
        #2;
    endtask

    task automatic wait_status_low();
        int waited;
        waited = 0;
        do begin
            @(negedge CLK);
            waited++;
            if (waited > WAIT_LIMIT) abort_on_timeout("STATUS to fall");
        end while (STATUS);
        @(posedge CLK);
        #2;
    endtask

    function automatic string verdict(input int errs_before);
        return (errors == errs_before) ? "ok" : "with errors";
    endfunction

    initial begin
        int errs_before;
        void'($urandom(54));
        RESET              = 1'b1;
        RUN                = 1'b0;
        STOP               = 1'b0;
        MEM_BASEADDR       = 32'h1000_0F00;
        MEM_BASEADDR_VALID = 1'b0;
        MEM_HIGHADDR       = 32'h1000_1700;
        S_AXIS_TDATA       = '0;
        S_AXIS_TVALID      = 1'b0;
        S_AXIS_TLAST       = 1'b0;
        M_AXI_AWREADY      = 1'b0;
        M_AXI_WREADY       = 1'b0;
        M_AXI_BVALID       = 1'b0;
        model_addr         = 32'h1000_0F00;
        for (int p = 0; p < NUM_PKTS; p++) begin
            pkt_len[p] = 1 + ($urandom % MAX_LEN);
            for (int w = 0; w < MAX_LEN; w++) begin
                data_pool[p * MAX_LEN + w] = $urandom;
                gap_pool[p * MAX_LEN + w]  = (($urandom % 4) == 0) ? 1 + ($urandom % 2) : 0;
            end
        end
        // stop test packet overflows the fifo so it is still in flight at STOP
        pkt_len[50] = MAX_LEN;

        repeat (10) @(posedge CLK);
        #2;
        RESET = 1'b0;

        // random packets through the ring with wrap
        errs_before = errors;
        pulse_run();
        for (int p = 0; p < 50; p++) send_packet(p);
        wait_model_drained();
        if (wraps == 0) report_error("no write restarted at the base address after the high address");
        $display("test 1 random packets: %s", verdict(errs_before));

        // stop during a packet
        errs_before = errors;
        send_packet(50);
        STOP = 1'b1;
        @(posedge CLK);
        #2;
        STOP = 1'b0;
        if (!STATUS) report_error("STATUS low while the stopped packet is in flight");
        wait_status_low();
        wait_model_drained();
        S_AXIS_TVALID = 1'b1;
        S_AXIS_TDATA  = 32'hDEAD_BEEF;
        repeat (40) begin
            @(negedge CLK);
            if (M_AXI_AWVALID) report_error("address burst issued after stop");
            if (S_AXIS_TREADY) report_error("stream accepted data after stop");
            if (STATUS) report_error("STATUS high after stop");
            @(posedge CLK);
            #2;
        end
        S_AXIS_TVALID = 1'b0;
        $display("test 2 stop: %s", verdict(errs_before));

        // base reload in IDLE, then restart
        errs_before        = errors;
        MEM_BASEADDR       = 32'h2000_0FC0;
        MEM_HIGHADDR       = 32'h2000_1400;
        MEM_BASEADDR_VALID = 1'b1;
        @(posedge CLK);
        #2;
        MEM_BASEADDR_VALID = 1'b0;
        model_addr         = 32'h2000_0FC0;
        expect_base        = 1'b1;
        pulse_run();
        for (int p = 51; p < NUM_PKTS; p++) send_packet(p);
        wait_model_drained();
        $display("test 3 base reload: %s", verdict(errs_before));

        checks++;
        if (beats_seen != words_sent) begin
            errors++;
            $display("mismatch at %0t: beat total got %0d expected %0d", $time,
                     beats_seen, words_sent);
        end
        $display("tests: 3, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tests/axi_packet_writer_sva.sv ====
`timescale 1ns/10ps
`include "mem_writer_cfg.svh"

module axi_packet_writer_sva (
    input logic               CLK,
    input logic               RESET,
    input logic               awvalid,
    input logic               awready,
    input axi_wr_pkg::addr_t  awaddr,
    input axi_wr_pkg::awlen_t awlen,
    input logic               wvalid,
    input logic               wready
);
    import axi_wr_pkg::*;

    logic [31:0] burst_end;

    // first byte past the burst, relative to its 4 KB region
    assign burst_end = 32'(awaddr[11:0]) + ((32'(awlen) + 1) * `WR_BYTES_PER_WORD);

    aw_hold: assert property (@(posedge CLK) disable iff (RESET)
        (awvalid && !awready) |=> awvalid)
        else $error("AWVALID dropped before AWREADY");

    w_hold: assert property (@(posedge CLK) disable iff (RESET)
        (wvalid && !wready) |=> wvalid)
        else $error("WVALID dropped before WREADY");

    no_4k_cross: assert property (@(posedge CLK) disable iff (RESET)
        awvalid |-> (burst_end <= 32'(`WR_BOUND_BYTES)))
        else $error("burst crosses the 4 KB boundary");

    len_limit: assert property (@(posedge CLK) disable iff (RESET)
        awvalid |-> (32'(awlen) <= (`WR_BURST_LIMIT - 1)))
        else $error("AWLEN above the burst limit");

endmodule

bind axi_packet_writer axi_packet_writer_sva i_axi_packet_writer_sva (
    .CLK     (CLK),
    .RESET   (RESET),
    .awvalid (M_AXI_AWVALID),
    .awready (M_AXI_AWREADY),
    .awaddr  (M_AXI_AWADDR),
    .awlen   (M_AXI_AWLEN),
    .wvalid  (M_AXI_WVALID),
    .wready  (M_AXI_WREADY)
);

// ==== rtl/axi_packet_writer.sv ====
`timescale 1ns/10ps
`include "mem_writer_cfg.svh"

module axi_packet_writer (
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic                        RUN,
    input  logic                        STOP,
    input  axi_wr_pkg::addr_t           MEM_BASEADDR,
    input  logic                        MEM_BASEADDR_VALID,
    input  axi_wr_pkg::addr_t           MEM_HIGHADDR,
    input  axi_wr_pkg::data_t           S_AXIS_TDATA,
    input  logic                        S_AXIS_TVALID,
    input  logic                        S_AXIS_TLAST,
    output logic                        S_AXIS_TREADY,
    output axi_wr_pkg::addr_t           M_AXI_AWADDR,
    output axi_wr_pkg::awlen_t          M_AXI_AWLEN,
    output logic                        M_AXI_AWVALID,
    input  logic                        M_AXI_AWREADY,
    output axi_wr_pkg::data_t           M_AXI_WDATA,
    output logic                        M_AXI_WLAST,
    output logic                        M_AXI_WVALID,
    input  logic                        M_AXI_WREADY,
    input  logic                        M_AXI_BVALID,
    output logic                        M_AXI_BREADY,
    output logic                        STATUS,
    output writer_ctl_pkg::byte_count_t TRANSMITTED_BYTES,
    output logic                        TRANSMITTED_FLAG,
    output axi_wr_pkg::addr_t           CURRENT_ADDRESS
);
    import writer_ctl_pkg::*;

    word_count_t fifo_words;
    word_count_t head_len;
    logic        len_valid;
    logic        rd_last;
    logic        rd_en;
    logic        beat_done;
    logic        plan_req;
    logic        burst_done;
    logic        pkt_done;
    logic        accept_en;
    logic        flush;

    packet_fifo i_packet_fifo (
        .CLK        (CLK),
        .RESET      (RESET),
        .flush      (flush),
        .s_tdata    (S_AXIS_TDATA),
        .s_tvalid   (S_AXIS_TVALID),
        .s_tlast    (S_AXIS_TLAST),
        .accept_en  (accept_en),
        .s_tready   (S_AXIS_TREADY),
        .rd_en      (rd_en),
        .rd_data    (M_AXI_WDATA),
        .rd_last    (rd_last),
        .fifo_words (fifo_words)
    );

    packet_length_queue i_packet_length_queue (
        .CLK       (CLK),
        .RESET     (RESET),
        .flush     (flush),
        .s_tvalid  (S_AXIS_TVALID),
        .s_tready  (S_AXIS_TREADY),
        .s_tlast   (S_AXIS_TLAST),
        .accept_en (accept_en),
        .beat_done (beat_done),
        .len_valid (len_valid),
        .head_len  (head_len)
    );

    burst_planner i_burst_planner (
        .CLK                (CLK),
        .RESET              (RESET),
        .mem_baseaddr       (MEM_BASEADDR),
        .mem_baseaddr_valid (MEM_BASEADDR_VALID),
        .mem_highaddr       (MEM_HIGHADDR),
        .plan_req           (plan_req),
        .fifo_words         (fifo_words),
        .head_len           (head_len),
        .len_valid          (len_valid),
        .burst_done         (burst_done),
        .pkt_done           (pkt_done),
        .awaddr             (M_AXI_AWADDR),
        .awlen              (M_AXI_AWLEN),
        .pkt_addr           (CURRENT_ADDRESS)
    );

    write_sequencer i_write_sequencer (
        .CLK               (CLK),
        .RESET             (RESET),
        .run               (RUN),
        .stop              (STOP),
        .fifo_words        (fifo_words),
        .len_valid         (len_valid),
        .rd_last           (rd_last),
        .awlen             (M_AXI_AWLEN),
        .awready           (M_AXI_AWREADY),
        .wready            (M_AXI_WREADY),
        .bvalid            (M_AXI_BVALID),
        .awvalid           (M_AXI_AWVALID),
        .wvalid            (M_AXI_WVALID),
        .wlast             (M_AXI_WLAST),
        .bready            (M_AXI_BREADY),
        .rd_en             (rd_en),
        .beat_done         (beat_done),
        .plan_req          (plan_req),
        .burst_done        (burst_done),
        .pkt_done          (pkt_done),
        .accept_en         (accept_en),
        .flush             (flush),
        .status            (STATUS),
        .transmitted_flag  (TRANSMITTED_FLAG),
        .transmitted_bytes (TRANSMITTED_BYTES)
    );

endmodule

// ==== rtl/write_sequencer.sv ====
`timescale 1ns/10ps
`include "mem_writer_cfg.svh"

module write_sequencer (
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic                        run,
    input  logic                        stop,
    input  writer_ctl_pkg::word_count_t fifo_words,
    input  logic                        len_valid,
    input  logic                        rd_last,
    input  axi_wr_pkg::awlen_t          awlen,
    input  logic                        awready,
    input  logic                        wready,
    input  logic                        bvalid,
    output logic                        awvalid,
    output logic                        wvalid,
    output logic                        wlast,
    output logic                        bready,
    output logic                        rd_en,
    output logic                        beat_done,
    output logic                        plan_req,
    output logic                        burst_done,
    output logic                        pkt_done,
    output logic                        accept_en,
    output logic                        flush,
    output logic                        status,
    output logic                        transmitted_flag,
    output writer_ctl_pkg::byte_count_t transmitted_bytes
);
    import axi_wr_pkg::*;
    import writer_ctl_pkg::*;

    wr_state_e state;
    logic      armed;
    logic      stop_seen;
    logic      pkt_end;
    awlen_t    beat_cnt;
    logic      data_ready;
    logic      w_xfer;
    logic      b_xfer;
    logic      leave_idle;

    // whole packet queued, or more than one full burst buffered
    assign data_ready = len_valid | (fifo_words > word_count_t'(`WR_BURST_LIMIT));
    assign w_xfer     = wvalid & wready;
    assign b_xfer     = bvalid & bready;
    assign wlast      = wvalid & (beat_cnt == awlen);
    assign leave_idle = (state == IDLE) & (run | (armed & ~stop_seen & ~stop));

    assign rd_en      = w_xfer;
    assign beat_done  = w_xfer;
    assign plan_req   = (state == ADDR);
    assign burst_done = b_xfer;
    assign pkt_done   = b_xfer & pkt_end;
    assign flush      = (state == IDLE) & ~armed;
    assign status     = (state != IDLE);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      if (leave_idle) state <= WAIT_DATA;
                WAIT_DATA: if (data_ready) state <= ADDR;
                ADDR:      state <= WRITE;
                WRITE:     if (w_xfer && wlast) state <= WAIT_RESP;
                WAIT_RESP: begin
                    if (b_xfer) begin
                        if (pkt_end) begin
                            state <= IDLE;
                        end else if (data_ready) begin
                            state <= ADDR;
                        end else begin
                            state <= WAIT_DATA;
                        end
                    end
                end
                default:   state <= IDLE;
            endcase
        end
    end

    // stop is honoured only between packets
    always_ff @(posedge CLK) begin
        if (RESET) begin
            armed     <= 1'b0;
            stop_seen <= 1'b0;
            accept_en <= 1'b0;
        end else if (state == IDLE) begin
            if (run) begin
                armed     <= 1'b1;
                accept_en <= 1'b1;
                stop_seen <= 1'b0;
            end else if (stop || stop_seen) begin
                armed     <= 1'b0;
                accept_en <= 1'b0;
                stop_seen <= 1'b0;
            end
        end else if (stop) begin
            stop_seen <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            awvalid          <= 1'b0;
            wvalid           <= 1'b0;
            bready           <= 1'b1;
            transmitted_flag <= 1'b0;
            beat_cnt         <= '0;
            pkt_end          <= 1'b0;
        end else begin
            if (state == ADDR) begin
                awvalid <= 1'b1;
            end else if (awvalid && awready) begin
                awvalid <= 1'b0;
            end
            if (awvalid && awready) begin
                wvalid <= 1'b1;
            end else if (w_xfer && wlast) begin
                wvalid <= 1'b0;
            end
            if (state == ADDR) begin
                beat_cnt <= '0;
            end else if (w_xfer) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            // final beat tells whether the burst closed the packet
            if (w_xfer && wlast) begin
                pkt_end <= rd_last;
            end
            bready           <= ~b_xfer;
            transmitted_flag <= b_xfer & pkt_end;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET || leave_idle) begin
            transmitted_bytes <= '0;
        end else if (w_xfer) begin
            transmitted_bytes <= transmitted_bytes + byte_count_t'(`WR_BYTES_PER_WORD);
        end
    end

endmodule

// ==== rtl/burst_planner.sv ====
`timescale 1ns/10ps
`include "mem_writer_cfg.svh"

module burst_planner (
    input  logic                        CLK,
    input  logic                        RESET,
    input  axi_wr_pkg::addr_t           mem_baseaddr,
    input  logic                        mem_baseaddr_valid,
    input  axi_wr_pkg::addr_t           mem_highaddr,
    input  logic                        plan_req,
    input  writer_ctl_pkg::word_count_t fifo_words,
    input  writer_ctl_pkg::word_count_t head_len,
    input  logic                        len_valid,
    input  logic                        burst_done,
    input  logic                        pkt_done,
    output axi_wr_pkg::addr_t           awaddr,
    output axi_wr_pkg::awlen_t          awlen,
    output axi_wr_pkg::addr_t           pkt_addr
);
    import axi_wr_pkg::*;
    import writer_ctl_pkg::*;

    localparam int OFFS_W  = $clog2(`WR_BOUND_BYTES);
    localparam int SIZE_SH = $clog2(`WR_BYTES_PER_WORD);

    addr_t             cur_addr;
    addr_t             next_addr;
    logic [OFFS_W-1:0] bound_offs;
    word_count_t       bound_m1;
    word_count_t       avail_m1;
    word_count_t       len_m1;
    logic              pkt_start;

    // words to the boundary kept as minus one, an aligned 4 KB start needs 1024
    assign bound_offs = cur_addr[OFFS_W-1:0];
    assign bound_m1   = word_count_t'(((`WR_BOUND_BYTES - 1) - bound_offs) >> SIZE_SH);
    assign avail_m1   = (len_valid ? head_len : fifo_words) - 1'b1;
    assign next_addr  = cur_addr + ((addr_t'(awlen) + 1'b1) << SIZE_SH);

    // smallest of limit, boundary and data on hand
    always_comb begin
        len_m1 = word_count_t'(`WR_BURST_LIMIT - 1);
        if (bound_m1 < len_m1) begin
            len_m1 = bound_m1;
        end
        if (avail_m1 < len_m1) begin
            len_m1 = avail_m1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET || mem_baseaddr_valid) begin
            cur_addr <= mem_baseaddr;
        end else if (burst_done) begin
            if (pkt_done && (next_addr >= mem_highaddr)) begin
                cur_addr <= mem_baseaddr;
            end else begin
                cur_addr <= next_addr;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (plan_req) begin
            awaddr <= cur_addr;
            awlen  <= awlen_t'(len_m1);
        end
        if (plan_req && pkt_start) begin
            pkt_addr <= cur_addr;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pkt_start <= 1'b1;
        end else if (plan_req) begin
            pkt_start <= 1'b0;
        end else if (pkt_done) begin
            pkt_start <= 1'b1;
        end
    end

endmodule

// ==== rtl/packet_length_queue.sv ====
`timescale 1ns/10ps
`include "mem_writer_cfg.svh"

module packet_length_queue (
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic                        flush,
    input  logic                        s_tvalid,
    input  logic                        s_tready,
    input  logic                        s_tlast,
    input  logic                        accept_en,
    input  logic                        beat_done,
    output logic                        len_valid,
    output writer_ctl_pkg::word_count_t head_len
);
    import writer_ctl_pkg::*;

    // every queued packet still owns at least one word in the data fifo
    localparam int PTR_W = $clog2(`WR_FIFO_DEPTH);

    word_count_t      len_mem [`WR_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   entries;
    word_count_t      arrive_cnt;
    word_count_t      beats_out;
    logic             xfer;
    logic             push;
    logic             pop;

    assign xfer      = s_tvalid & s_tready & accept_en;
    assign push      = xfer & s_tlast;
    assign len_valid = (entries != '0);
    assign head_len  = len_mem[rd_ptr] - beats_out;
    assign pop       = beat_done & len_valid & (head_len == word_count_t'(1));

    always_ff @(posedge CLK) begin
        if (push) begin
            len_mem[wr_ptr] <= arrive_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET || flush) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            entries    <= '0;
            arrive_cnt <= '0;
            beats_out  <= '0;
        end else begin
            if (xfer) begin
                arrive_cnt <= s_tlast ? '0 : arrive_cnt + 1'b1;
            end
            // beats of a packet still arriving count too
            if (pop) begin
                beats_out <= '0;
                rd_ptr    <= rd_ptr + 1'b1;
            end else if (beat_done) begin
                beats_out <= beats_out + 1'b1;
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   entries <= entries + 1'b1;
                2'b01:   entries <= entries - 1'b1;
                default: entries <= entries;
            endcase
        end
    end

endmodule

// ==== rtl/packet_fifo.sv ====
`timescale 1ns/10ps
`include "mem_writer_cfg.svh"

module packet_fifo (
    input  logic                        CLK,
    input  logic                        RESET,
    input  logic                        flush,
    input  axi_wr_pkg::data_t           s_tdata,
    input  logic                        s_tvalid,
    input  logic                        s_tlast,
    input  logic                        accept_en,
    output logic                        s_tready,
    input  logic                        rd_en,
    output axi_wr_pkg::data_t           rd_data,
    output logic                        rd_last,
    output writer_ctl_pkg::word_count_t fifo_words
);
    import axi_wr_pkg::*;
    import writer_ctl_pkg::*;

    // depth is a power of two, pointers wrap on their own
    localparam int PTR_W = $clog2(`WR_FIFO_DEPTH);

    data_t            mem_data [`WR_FIFO_DEPTH];
    logic             mem_last [`WR_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    word_count_t      count;
    logic             full;
    logic             wr_en;
    logic             rd_ok;

    assign full     = (count == word_count_t'(`WR_FIFO_DEPTH));
    assign s_tready = accept_en & ~full;
    assign wr_en    = s_tvalid & s_tready;
    assign rd_ok    = rd_en & (count != '0);

    // show-ahead read of the head word
    assign rd_data    = mem_data[rd_ptr];
    assign rd_last    = mem_last[rd_ptr];
    assign fifo_words = count;

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= s_tdata;
            mem_last[wr_ptr] <= s_tlast;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== rtl/writer_ctl_pkg.sv ====
`include "mem_writer_cfg.svh"

package writer_ctl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_DATA,
        ADDR,
        WRITE,
        WAIT_RESP
    } wr_state_e;

    // fifo occupancy, packet length, words to boundary
    typedef logic [9:0] word_count_t;

    // bytes sent for one packet, spans the address range
    typedef logic [`WR_ADDR_W-1:0] byte_count_t;

endpackage

// ==== rtl/axi_wr_pkg.sv ====
`include "mem_writer_cfg.svh"

package axi_wr_pkg;

    // byte address on the AW channel
    typedef logic [`WR_ADDR_W-1:0] addr_t;

    // one stream or W data word
    typedef logic [`WR_DATA_W-1:0] data_t;

    // beats minus one, as on AWLEN
    typedef logic [7:0] awlen_t;

endpackage

// ==== rtl/mem_writer_cfg.svh ====
`ifndef MEM_WRITER_CFG_SVH
`define MEM_WRITER_CFG_SVH

// stream and W data width in bits
`define WR_DATA_W 32
`define WR_ADDR_W 32

// max beats per AW burst
`define WR_BURST_LIMIT 16
`define WR_FIFO_DEPTH (2 * `WR_BURST_LIMIT)
`define WR_BOUND_BYTES 4096
`define WR_BYTES_PER_WORD (`WR_DATA_W / 8)

// side-band fields tied at the interconnect
// awsize = log2 of bytes per word, awburst = incr, awlock/awcache/awprot = 0
// wstrb = all ones

`endif
